// File: hdl/pipe_pkg.sv
package pipe_pkg;

  parameter int XLEN = 32;
  parameter int NUM_REGS = 16;
  // queue occupancy, enough for depths up to 32
  parameter int COUNT_BITS = 6;

  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_type;
  typedef logic [XLEN-1:0] data_type;

  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_addi = 4'd5,
    op_lw   = 4'd6,
    op_sw   = 4'd7
  } opcode_type;

  typedef enum logic [1:0] {
    fe_idle,
    fe_ack,
    fe_wait_space
  } fe_state_type;

  typedef struct packed {
    logic [3:0] opcode;
    reg_addr_type rd;
    reg_addr_type rs1;
    reg_addr_type rs2;
    logic [15:0] imm;
  } instr_type;

  typedef struct packed {
    opcode_type op;
    logic rden1;
    logic rden2;
    logic wren;
    logic mem;
  } decode_type;

  // unknown opcodes decode as nop
  function automatic decode_type decode(data_type word);
    decode_type d;
    instr_type f;
    f = instr_type'(word);
    d = '0;
    case (f.opcode)
      op_add, op_sub, op_and, op_or: begin
        d.op = opcode_type'(f.opcode);
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.wren = 1'b1;
      end
      op_addi: begin
        d.op = op_addi;
        d.rden1 = 1'b1;
        d.wren = 1'b1;
      end
      op_lw: begin
        d.op = op_lw;
        d.rden1 = 1'b1;
        d.wren = 1'b1;
        d.mem = 1'b1;
      end
      op_sw: begin
        d.op = op_sw;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.mem = 1'b1;
      end
      default: begin
        d.op = op_nop;
      end
    endcase
    return d;
  endfunction

endpackage

// File: hdl/bus_front_end.sv
`timescale 1ns/1ns

module bus_front_end #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [5:0] adr,
  input  pipe_pkg::data_type dat_w,
  input  logic [1:0] pop_count,
  input  pipe_pkg::data_type debug_data,
  output pipe_pkg::data_type dat_r,
  output logic ack,
  output pipe_pkg::data_type head0,
  output pipe_pkg::data_type head1,
  output logic [pipe_pkg::COUNT_BITS-1:0] count,
  output pipe_pkg::reg_addr_type debug_addr
);

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

  pipe_pkg::fe_state_type state;
  pipe_pkg::fe_state_type state_next;
  pipe_pkg::data_type queue [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] rd_ptr_1;
  logic is_push;
  logic space;
  logic push;

  assign rd_ptr_1 = rd_ptr + 1'b1;
  assign head0 = queue[rd_ptr];
  assign head1 = queue[rd_ptr_1];
  assign debug_addr = adr[3:0];
  assign ack = (state == pipe_pkg::fe_ack);

  // a pop in the same cycle frees the slot being written
  assign space = (count < QUEUE_DEPTH) || (pop_count != 2'd0);
  assign is_push = cyc && stb && we && adr[5];

  // ********************
  // wishbone handshake
  // ********************
  always_comb begin
    state_next = state;
    push = 1'b0;
    case (state)
      pipe_pkg::fe_idle: begin
        if (cyc && stb) begin
          if (is_push && !space) begin
            state_next = pipe_pkg::fe_wait_space;
          end else begin
            push = is_push;
            state_next = pipe_pkg::fe_ack;
          end
        end
      end
      pipe_pkg::fe_wait_space: begin
        if (space) begin
          push = 1'b1;
          state_next = pipe_pkg::fe_ack;
        end
      end
      default: begin
        state_next = pipe_pkg::fe_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= pipe_pkg::fe_idle;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      state <= state_next;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + PTR_BITS'(pop_count);
      count <= count + pipe_pkg::COUNT_BITS'(push) - pipe_pkg::COUNT_BITS'(pop_count);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      queue[wr_ptr] <= dat_w;
    end
    // register read-back
    if (state == pipe_pkg::fe_idle && cyc && stb && !we) begin
      dat_r <= debug_data;
    end
  end

endmodule

// File: hdl/pair_select.sv
`timescale 1ns/1ns

module pair_select (
  input  pipe_pkg::data_type head0,
  input  pipe_pkg::data_type head1,
  input  logic [pipe_pkg::COUNT_BITS-1:0] count,
  input  logic hold,
  output pipe_pkg::data_type lane0_word,
  output pipe_pkg::data_type lane1_word,
  output logic lane0_valid,
  output logic lane1_valid,
  output logic [1:0] pop_count
);

  pipe_pkg::instr_type f0;
  pipe_pkg::instr_type f1;
  pipe_pkg::decode_type dec0;
  pipe_pkg::decode_type dec1;
  logic first_writes;
  logic raw_dep;
  logic same_rd;
  logic pair_ok;

  assign f0 = pipe_pkg::instr_type'(head0);
  assign f1 = pipe_pkg::instr_type'(head1);
  assign dec0 = pipe_pkg::decode(head0);
  assign dec1 = pipe_pkg::decode(head1);

  // ********************
  // pairing rule
  // ********************
  assign first_writes = dec0.wren && (f0.rd != '0);

  // second reads what the first produces
  assign raw_dep = first_writes &&
                   ((dec1.rden1 && (f1.rs1 == f0.rd)) ||
                    (dec1.rden2 && (f1.rs2 == f0.rd)));

  assign same_rd = first_writes && dec1.wren && (f1.rd == f0.rd);

  // memory ops only run in lane 0
  assign pair_ok = !raw_dep && !same_rd && !dec1.mem;

  assign lane0_word = head0;
  assign lane1_word = head1;
  assign lane0_valid = (count != '0);
  assign lane1_valid = (count >= 2) && pair_ok;

  always_comb begin
    if (hold) begin
      pop_count = 2'd0;
    end else begin
      pop_count = {1'b0, lane0_valid} + {1'b0, lane1_valid};
    end
  end

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
  input  logic clock,
  input  logic reset,
  input  pipe_pkg::data_type lane0_word,
  input  pipe_pkg::data_type lane1_word,
  input  logic lane0_valid,
  input  logic lane1_valid,
  input  pipe_pkg::data_type rdata0a,
  input  pipe_pkg::data_type rdata0b,
  input  pipe_pkg::data_type rdata1a,
  input  pipe_pkg::data_type rdata1b,
  input  logic ex_load_valid,
  input  pipe_pkg::reg_addr_type ex_load_rd,
  output logic hold,
  output pipe_pkg::reg_addr_type raddr0a,
  output pipe_pkg::reg_addr_type raddr0b,
  output pipe_pkg::reg_addr_type raddr1a,
  output pipe_pkg::reg_addr_type raddr1b,
  output logic iss0_valid,
  output pipe_pkg::opcode_type iss0_op,
  output pipe_pkg::reg_addr_type iss0_rd,
  output pipe_pkg::data_type iss0_a,
  output pipe_pkg::data_type iss0_b,
  output pipe_pkg::data_type iss0_store,
  output logic iss1_valid,
  output pipe_pkg::opcode_type iss1_op,
  output pipe_pkg::reg_addr_type iss1_rd,
  output pipe_pkg::data_type iss1_a,
  output pipe_pkg::data_type iss1_b,
  output logic issue_busy
);

  pipe_pkg::data_type word0_q;
  pipe_pkg::data_type word1_q;
  logic valid0_q;
  logic valid1_q;
  pipe_pkg::instr_type f0;
  pipe_pkg::instr_type f1;
  pipe_pkg::decode_type dec0;
  pipe_pkg::decode_type dec1;
  logic load_hit0;
  logic load_hit1;
  logic port_clash;

  // immediate for addi, address offset for memory ops
  function automatic pipe_pkg::data_type operand_b(pipe_pkg::decode_type dec,
                                                   pipe_pkg::instr_type f,
                                                   pipe_pkg::data_type rdata);
    if (dec.op == pipe_pkg::op_addi || dec.mem) begin
      return {{16{f.imm[15]}}, f.imm};
    end
    return rdata;
  endfunction

  assign f0 = pipe_pkg::instr_type'(word0_q);
  assign f1 = pipe_pkg::instr_type'(word1_q);
  assign dec0 = pipe_pkg::decode(word0_q);
  assign dec1 = pipe_pkg::decode(word1_q);

  assign raddr0a = f0.rs1;
  assign raddr0b = f0.rs2;
  assign raddr1a = f1.rs1;
  assign raddr1b = f1.rs2;

  // ********************
  // load-use stall
  // ********************
  assign load_hit0 = (dec0.rden1 && (f0.rs1 == ex_load_rd)) ||
                     (dec0.rden2 && (f0.rs2 == ex_load_rd));
  assign load_hit1 = (dec1.rden1 && (f1.rs1 == ex_load_rd)) ||
                     (dec1.rden2 && (f1.rs2 == ex_load_rd));

  // loaded data owns write port 0 in the next cycle
  assign port_clash = dec0.wren && (dec0.op != pipe_pkg::op_lw);

  assign hold = ex_load_valid &&
                ((valid0_q && (load_hit0 || port_clash)) || (valid1_q && load_hit1));

  assign issue_busy = valid0_q || valid1_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid0_q <= 1'b0;
      valid1_q <= 1'b0;
      iss0_valid <= 1'b0;
      iss1_valid <= 1'b0;
    end else begin
      if (!hold) begin
        valid0_q <= lane0_valid;
        valid1_q <= lane1_valid;
      end
      // bubble into execute while held
      iss0_valid <= valid0_q && !hold;
      iss1_valid <= valid1_q && !hold;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      word0_q <= lane0_word;
      word1_q <= lane1_word;
    end
    iss0_op <= dec0.op;
    iss0_rd <= f0.rd;
    iss0_a <= rdata0a;
    iss0_b <= operand_b(dec0, f0, rdata0b);
    iss0_store <= rdata0b;
    iss1_op <= dec1.op;
    iss1_rd <= f1.rd;
    iss1_a <= rdata1a;
    iss1_b <= operand_b(dec1, f1, rdata1b);
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ns

module register_file (
  input  logic clock,
  input  logic reset,
  input  pipe_pkg::reg_addr_type raddr0a,
  input  pipe_pkg::reg_addr_type raddr0b,
  input  pipe_pkg::reg_addr_type raddr1a,
  input  pipe_pkg::reg_addr_type raddr1b,
  input  pipe_pkg::reg_addr_type debug_addr,
  input  logic we0,
  input  pipe_pkg::reg_addr_type waddr0,
  input  pipe_pkg::data_type wdata0,
  input  logic we1,
  input  pipe_pkg::reg_addr_type waddr1,
  input  pipe_pkg::data_type wdata1,
  output pipe_pkg::data_type rdata0a,
  output pipe_pkg::data_type rdata0b,
  output pipe_pkg::data_type rdata1a,
  output pipe_pkg::data_type rdata1b,
  output pipe_pkg::data_type debug_data
);

  pipe_pkg::data_type regs [pipe_pkg::NUM_REGS];

  // write-through, lane 1 first
  function automatic pipe_pkg::data_type read_port(pipe_pkg::reg_addr_type addr);
    if (addr == '0) begin
      return '0;
    end else if (we1 && (waddr1 == addr)) begin
      return wdata1;
    end else if (we0 && (waddr0 == addr)) begin
      return wdata0;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata0a = read_port(raddr0a);
    rdata0b = read_port(raddr0b);
    rdata1a = read_port(raddr1a);
    rdata1b = read_port(raddr1b);
    debug_data = read_port(debug_addr);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0 && (waddr0 != '0)) begin
        regs[waddr0] <= wdata0;
      end
      if (we1 && (waddr1 != '0)) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage #(
  parameter int DATA_WORDS = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic iss0_valid,
  input  pipe_pkg::opcode_type iss0_op,
  input  pipe_pkg::reg_addr_type iss0_rd,
  input  pipe_pkg::data_type iss0_a,
  input  pipe_pkg::data_type iss0_b,
  input  pipe_pkg::data_type iss0_store,
  input  logic iss1_valid,
  input  pipe_pkg::opcode_type iss1_op,
  input  pipe_pkg::reg_addr_type iss1_rd,
  input  pipe_pkg::data_type iss1_a,
  input  pipe_pkg::data_type iss1_b,
  output logic we0,
  output pipe_pkg::reg_addr_type waddr0,
  output pipe_pkg::data_type wdata0,
  output logic we1,
  output pipe_pkg::reg_addr_type waddr1,
  output pipe_pkg::data_type wdata1,
  output logic ex_load_valid,
  output pipe_pkg::reg_addr_type ex_load_rd,
  output logic exec_busy
);

  localparam int ADDR_BITS = $clog2(DATA_WORDS);

  pipe_pkg::data_type ram [DATA_WORDS];
  pipe_pkg::data_type result0;
  pipe_pkg::data_type result1;
  logic [ADDR_BITS-1:0] mem_addr;
  logic mem_valid;
  pipe_pkg::reg_addr_type mem_rd;
  pipe_pkg::data_type mem_data;

  // memory ops use the add path for the address
  function automatic pipe_pkg::data_type alu(pipe_pkg::opcode_type op,
                                             pipe_pkg::data_type a,
                                             pipe_pkg::data_type b);
    case (op)
      pipe_pkg::op_sub: return a - b;
      pipe_pkg::op_and: return a & b;
      pipe_pkg::op_or: return a | b;
      default: return a + b;
    endcase
  endfunction

  function automatic logic alu_writes(pipe_pkg::opcode_type op);
    return op inside {pipe_pkg::op_add, pipe_pkg::op_sub, pipe_pkg::op_and,
                      pipe_pkg::op_or, pipe_pkg::op_addi};
  endfunction

  assign result0 = alu(iss0_op, iss0_a, iss0_b);
  assign result1 = alu(iss1_op, iss1_a, iss1_b);
  assign mem_addr = ADDR_BITS'(result0 % pipe_pkg::data_type'(DATA_WORDS));

  assign ex_load_valid = iss0_valid && (iss0_op == pipe_pkg::op_lw);
  assign ex_load_rd = iss0_rd;
  assign exec_busy = iss0_valid || iss1_valid || mem_valid;

  // ********************
  // writeback ports
  // ********************
  always_comb begin
    if (mem_valid) begin
      we0 = 1'b1;
      waddr0 = mem_rd;
      wdata0 = mem_data;
    end else begin
      we0 = iss0_valid && alu_writes(iss0_op);
      waddr0 = iss0_rd;
      wdata0 = result0;
    end
    we1 = iss1_valid && alu_writes(iss1_op);
    waddr1 = iss1_rd;
    wdata1 = result1;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= ex_load_valid;
    end
  end

  // data ram, read registered into the memory register
  always_ff @(posedge clock) begin
    if (iss0_valid && (iss0_op == pipe_pkg::op_sw)) begin
      ram[mem_addr] <= iss0_store;
    end
    mem_data <= ram[mem_addr];
    mem_rd <= iss0_rd;
  end

endmodule

// File: hdl/dual_issue_core.sv
`timescale 1ns/1ns

module dual_issue_core #(
  parameter int QUEUE_DEPTH = 8,
  parameter int DATA_WORDS = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [5:0] adr,
  input  pipe_pkg::data_type dat_w,
  output pipe_pkg::data_type dat_r,
  output logic ack,
  output logic idle
);

  pipe_pkg::data_type head0;
  pipe_pkg::data_type head1;
  logic [pipe_pkg::COUNT_BITS-1:0] count;
  logic [1:0] pop_count;
  pipe_pkg::reg_addr_type debug_addr;
  pipe_pkg::data_type debug_data;
  pipe_pkg::data_type lane0_word;
  pipe_pkg::data_type lane1_word;
  logic lane0_valid;
  logic lane1_valid;
  logic hold;
  pipe_pkg::reg_addr_type raddr0a;
  pipe_pkg::reg_addr_type raddr0b;
  pipe_pkg::reg_addr_type raddr1a;
  pipe_pkg::reg_addr_type raddr1b;
  pipe_pkg::data_type rdata0a;
  pipe_pkg::data_type rdata0b;
  pipe_pkg::data_type rdata1a;
  pipe_pkg::data_type rdata1b;
  logic iss0_valid;
  pipe_pkg::opcode_type iss0_op;
  pipe_pkg::reg_addr_type iss0_rd;
  pipe_pkg::data_type iss0_a;
  pipe_pkg::data_type iss0_b;
  pipe_pkg::data_type iss0_store;
  logic iss1_valid;
  pipe_pkg::opcode_type iss1_op;
  pipe_pkg::reg_addr_type iss1_rd;
  pipe_pkg::data_type iss1_a;
  pipe_pkg::data_type iss1_b;
  logic we0;
  pipe_pkg::reg_addr_type waddr0;
  pipe_pkg::data_type wdata0;
  logic we1;
  pipe_pkg::reg_addr_type waddr1;
  pipe_pkg::data_type wdata1;
  logic ex_load_valid;
  pipe_pkg::reg_addr_type ex_load_rd;
  logic issue_busy;
  logic exec_busy;

  bus_front_end #(.QUEUE_DEPTH(QUEUE_DEPTH)) front_end (.*);

  pair_select pairing (.*);

  issue_stage issue (.*);

  register_file regfile (.*);

  execute_stage #(.DATA_WORDS(DATA_WORDS)) execute (.*);

  // drained when nothing is queued or in flight
  assign idle = !((count != '0) || issue_busy || exec_busy);

endmodule

// File: verification/dual_issue_core_assert.sv
`timescale 1ns/1ns

module dual_issue_core_assert (
  input logic clock,
  input logic reset,
  input logic hold,
  input logic iss0_valid,
  input logic iss1_valid
);

  // a load-use stall lasts one cycle
  hold_single_cycle: assert property (@(posedge clock) disable iff (!reset)
    hold |=> !hold)
    else $error("hold stayed high for two consecutive cycles");

  // held lanes skip one execute cycle, then go out
  no_issue_on_hold: assert property (@(posedge clock) disable iff (!reset)
    $past(hold, 2) |-> (!$past(iss0_valid) && !$past(iss1_valid) && iss0_valid))
    else $error("a held lane was sent to execute during the stall or lost");

  reset_clears_valids: assert property (@(posedge clock)
    !reset |=> (!iss0_valid && !iss1_valid))
    else $error("issue valids not low after reset");

endmodule

bind issue_stage dual_issue_core_assert issue_checks (
  .clock(clock),
  .reset(reset),
  .hold(hold),
  .iss0_valid(iss0_valid),
  .iss1_valid(iss1_valid)
);

// File: verification/dual_issue_core_tb.sv
`timescale 1ns/1ns

module dual_issue_core_tb;

  localparam int QUEUE_DEPTH = 8;
  localparam int DATA_WORDS = 16;
  localparam int ACK_TIMEOUT = 200;
  localparam int IDLE_TIMEOUT = 500;

  logic clock;
  logic reset;
  logic cyc;
  logic stb;
  logic we;
  logic [5:0] adr;
  pipe_pkg::data_type dat_w;
  pipe_pkg::data_type dat_r;
  logic ack;
  logic idle;

  integer fd;
  integer code;
  integer checks;
  integer reg_index;
  logic [8*16-1:0] token;
  logic [8*128-1:0] rest;
  logic in_program;
  pipe_pkg::data_type instr_word;
  pipe_pkg::data_type expected_value;
  pipe_pkg::data_type read_value;

  dual_issue_core #(.QUEUE_DEPTH(QUEUE_DEPTH), .DATA_WORDS(DATA_WORDS)) UUT (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic apply_reset();
    reset = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    repeat (8) @(negedge clock);
    reset = 1'b1;
  endtask

  task automatic expect_idle(input logic expected);
    if (idle !== expected) begin
      abort_run($sformatf("FAILED idle got %h expected %h", idle, expected));
    end
  endtask

  // ********************
  // wishbone master
  // ********************
  task automatic bus_write(input pipe_pkg::data_type data);
    int cycles;
    @(negedge clock);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b1;
    adr = 6'b100000;
    dat_w = data;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        abort_run("timeout waiting for ack on an instruction write");
      end
    end while (!ack);
    // an accepted write leaves the core busy
    expect_idle(1'b0);
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input pipe_pkg::reg_addr_type index,
                          output pipe_pkg::data_type data);
    int cycles;
    @(negedge clock);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = {2'b00, index};
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        abort_run("timeout waiting for ack on a register read");
      end
    end while (!ack);
    data = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (!idle) begin
      @(negedge clock);
      cycles++;
      if (cycles > IDLE_TIMEOUT) begin
        abort_run("timeout waiting for the pipeline to drain");
      end
    end
  endtask

  task automatic compare_data(input pipe_pkg::reg_addr_type index,
                              input pipe_pkg::data_type got,
                              input pipe_pkg::data_type expected);
    if (got !== expected) begin
      abort_run($sformatf("FAILED reg %0d got %h expected %h", index, got, expected));
    end
  endtask

  initial begin
    reset = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    checks = 0;
    in_program = 1'b0;
    fd = $fopen("verification/dual_issue_tests.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the test file");
    end
    // token driven: test, instruction words, end, then register checks
    while ($fscanf(fd, "%s", token) == 1) begin
      if (token == "#") begin
        code = $fgets(rest, fd);
      end else if (token == "test") begin
        apply_reset();
        expect_idle(1'b1);
        in_program = 1'b1;
      end else if (token == "end") begin
        wait_idle();
        in_program = 1'b0;
      end else if (in_program) begin
        code = $sscanf(token, "%h", instr_word);
        if (code != 1) begin
          abort_run("bad instruction word in the test file");
        end
        bus_write(instr_word);
      end else begin
        code = $sscanf(token, "%d", reg_index);
        code = code + $fscanf(fd, "%h", expected_value);
        if (code != 2) begin
          abort_run("bad register check in the test file");
        end
        bus_read(reg_index[3:0], read_value);
        compare_data(reg_index[3:0], read_value, expected_value);
        checks++;
      end
    end
    $fclose(fd);
    if (checks == 0) begin
      abort_run("no register checks were found in the test file");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// File: verification/dual_issue_tests.txt
# test resets the core, hex words are instructions, end waits for the core to drain
# after end come pairs of register number (decimal) and expected value (hex)
# independent alu ops
test
51000005 52000123 5300ffff 540000f0
15120000 26410000 37340000 48140000
end
1 00000005 2 00000123 3 ffffffff 4 000000f0
5 00000128 6 000000eb 7 000000f0 8 000000f5
# second op reads the first one's rd
test
51000007 12110000 23210000 44320000
end
1 00000007 2 0000000e 3 00000007 4 0000000f
# load followed by immediate use
test
51001234 52000003 70210002 63000005 14330000 55300001
end
3 00001234 4 00002468 5 00001235
# store and load round trip, addresses wrap modulo the ram size
test
510000aa 52000014 7021000a 5300fffe 70320003
6400000e 65000011 66300010
end
3 fffffffe 4 000000aa 5 00000014 6 000000aa
# writes to register 0 are dropped
test
50000055 51000009 10110000 70010003 60000003 52000001
end
0 00000000 1 00000009 2 00000001
# burst longer than the queue
test
51000001 52000002 11120000 22120000 11120000 22120000 11120000
22120000 11120000 22120000 33120000 44120000 5510ffff
end
1 0000000b 2 00000007 3 00000003 4 0000000f 5 0000000a

// File: files.f
hdl/pipe_pkg.sv
hdl/bus_front_end.sv
hdl/pair_select.sv
hdl/issue_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/dual_issue_core.sv
verification/dual_issue_core_assert.sv
verification/dual_issue_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module dual_issue_core_tb \
  -f files.f -o dual_issue_sim
./obj_dir/dual_issue_sim
